/* clock_pkg.sv */
package clock_pkg;

    ////////////////////////////////////////
    // Digit and time word layout
    ////////////////////////////////////////
    localparam int BCD_W      = 4;                  // One BCD digit
    localparam int NUM_DIGITS = 6;                  // hh mm ss
    localparam int TIME_W     = NUM_DIGITS * BCD_W; // Full time word

    // Digit offsets inside a time word
    localparam int SEC_LO_POS  = 0;   // Seconds units
    localparam int SEC_HI_POS  = 4;   // Seconds tens
    localparam int MIN_LO_POS  = 8;   // Minutes units
    localparam int MIN_HI_POS  = 12;  // Minutes tens
    localparam int HOUR_LO_POS = 16;  // Hours units
    localparam int HOUR_HI_POS = 20;  // Hours tens

    ////////////////////////////////////////
    // Timing, simulation scale
    ////////////////////////////////////////
    localparam int TICK_DIV  = 8;  // clk cycles per second tick
    localparam int SCAN_HOLD = 4;  // clk cycles per display digit

    ////////////////////////////////////////
    // Reset values
    ////////////////////////////////////////
    // 12:00:00, midnight
    localparam logic [TIME_W-1:0] RESET_TIME = 24'h12_00_00;
    localparam logic              RESET_PM   = 1'b0;  // AM

    // Hour tens of 15 never occurs in a legal time
    localparam logic [TIME_W-1:0] ALARM_RESET_TIME = 24'hF0_00_00;

    // Segments a..g, active high
    localparam int SEG_W = 7;

endpackage

/* bcd_digit_counter.sv */
`timescale 1ns/1ps

module bcd_digit_counter #(
    parameter logic [clock_pkg::BCD_W-1:0] LIMIT = 4'd9,  // Last value before wrap
    parameter logic [clock_pkg::BCD_W-1:0] INIT  = 4'd0   // Value out of reset
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        inc,         // Count enable
    input  logic                        load,        // Parallel load, beats inc
    input  logic [clock_pkg::BCD_W-1:0] load_value,
    output logic [clock_pkg::BCD_W-1:0] value,
    output logic                        carry        // Wrap this cycle
);
    import clock_pkg::*;

    logic at_limit;

    assign at_limit = (value == LIMIT);
    assign carry    = inc && at_limit;  // Feeds next digit inc

    ////////////////////////////////////////
    // Digit register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            value <= INIT;
        end
        else if (load)
        begin
            value <= load_value;  // Load wins
        end
        else if (inc)
        begin
            if (at_limit)
                value <= '0;              // Wrap back to zero
            else
                value <= value + BCD_W'(1);
        end
    end

    // Loads are legal BCD, so the digit stays in its range
    value_in_range_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        value <= LIMIT
    ) else $error("bcd_digit_counter: value %0d above limit %0d", value, LIMIT);

endmodule

/* tick_prescaler.sv */
`timescale 1ns/1ps

module tick_prescaler (
    input  logic clk,
    input  logic arst_n,
    output logic second_tick  // One cycle every TICK_DIV
);
    import clock_pkg::*;

    logic [$clog2(TICK_DIV)-1:0] cycle_cnt;
    logic                        wrap;

    assign wrap = (cycle_cnt == $bits(cycle_cnt)'(TICK_DIV - 1));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cycle_cnt   <= '0;
            second_tick <= 1'b0;
        end
        else
        begin
            cycle_cnt   <= wrap ? '0 : cycle_cnt + 1'b1;
            second_tick <= wrap;  // First pulse TICK_DIV cycles out of reset
        end
    end

    // Keeper relies on ticks never back to back
    tick_single_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        second_tick |=> !second_tick
    ) else $error("tick_prescaler: second_tick high two cycles");

endmodule

/* time_keeper_12h.sv */
`timescale 1ns/1ps

module time_keeper_12h (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         second_tick,  // One cycle per second
    input  logic                         time_load,
    input  logic [clock_pkg::TIME_W-1:0] load_time,
    input  logic                         load_pm,
    output logic [clock_pkg::TIME_W-1:0] time_now,
    output logic                         pm,
    output logic                         time_step     // Time word just changed
);
    import clock_pkg::*;

    logic [BCD_W-1:0]   sec_lo, sec_hi, min_lo, min_hi;
    logic               sec_lo_carry, sec_hi_carry, min_lo_carry;
    logic               min_carry;                      // Hour advance
    logic [BCD_W-1:0]   hour_hi, hour_lo;
    logic [2*BCD_W-1:0] hour_bcd;
    logic               hour_is_11, hour_is_12;

    ////////////////////////////////////////
    // Seconds and minutes, ripple chain
    ////////////////////////////////////////
    bcd_digit_counter #(.LIMIT(4'd9), .INIT(RESET_TIME[SEC_LO_POS +: BCD_W])) sec_lo_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .inc        (second_tick),
        .load       (time_load),
        .load_value (load_time[SEC_LO_POS +: BCD_W]),
        .value      (sec_lo),
        .carry      (sec_lo_carry)
    );

    bcd_digit_counter #(.LIMIT(4'd5), .INIT(RESET_TIME[SEC_HI_POS +: BCD_W])) sec_hi_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .inc        (sec_lo_carry),
        .load       (time_load),
        .load_value (load_time[SEC_HI_POS +: BCD_W]),
        .value      (sec_hi),
        .carry      (sec_hi_carry)
    );

    bcd_digit_counter #(.LIMIT(4'd9), .INIT(RESET_TIME[MIN_LO_POS +: BCD_W])) min_lo_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .inc        (sec_hi_carry),
        .load       (time_load),
        .load_value (load_time[MIN_LO_POS +: BCD_W]),
        .value      (min_lo),
        .carry      (min_lo_carry)
    );

    bcd_digit_counter #(.LIMIT(4'd5), .INIT(RESET_TIME[MIN_HI_POS +: BCD_W])) min_hi_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .inc        (min_lo_carry),
        .load       (time_load),
        .load_value (load_time[MIN_HI_POS +: BCD_W]),
        .value      (min_hi),
        .carry      (min_carry)
    );

    ////////////////////////////////////////
    // Hours, 12 then 01, never 00
    ////////////////////////////////////////
    assign hour_bcd   = {hour_hi, hour_lo};
    assign hour_is_11 = (hour_bcd == 8'h11);
    assign hour_is_12 = (hour_bcd == 8'h12);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hour_hi <= RESET_TIME[HOUR_HI_POS +: BCD_W];
            hour_lo <= RESET_TIME[HOUR_LO_POS +: BCD_W];
            pm      <= RESET_PM;
        end
        else if (time_load)
        begin
            hour_hi <= load_time[HOUR_HI_POS +: BCD_W];
            hour_lo <= load_time[HOUR_LO_POS +: BCD_W];
            pm      <= load_pm;
        end
        else if (min_carry)
        begin
            if (hour_is_12)
            begin
                hour_hi <= '0;          // 12 -> 01
                hour_lo <= BCD_W'(1);
            end
            else if (hour_lo == BCD_W'(9))
            begin
                hour_hi <= BCD_W'(1);   // 09 -> 10
                hour_lo <= '0;
            end
            else
            begin
                hour_lo <= hour_lo + BCD_W'(1);
            end
            if (hour_is_11)
                pm <= ~pm;              // 11:59:59 -> 12:00:00 flips AM/PM
        end
    end

    // New time visible in the same cycle as the strobe
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            time_step <= 1'b0;
        else
            time_step <= second_tick || time_load;
    end

    assign time_now[SEC_LO_POS  +: BCD_W] = sec_lo;
    assign time_now[SEC_HI_POS  +: BCD_W] = sec_hi;
    assign time_now[MIN_LO_POS  +: BCD_W] = min_lo;
    assign time_now[MIN_HI_POS  +: BCD_W] = min_hi;
    assign time_now[HOUR_LO_POS +: BCD_W] = hour_lo;
    assign time_now[HOUR_HI_POS +: BCD_W] = hour_hi;

    hour_legal_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        (hour_bcd >= 8'h01) && (hour_bcd <= 8'h12) && (hour_lo <= BCD_W'(9))
    ) else $error("time_keeper_12h: illegal hour %h", hour_bcd);

    // Top level holds set_ready low on tick cycles
    no_load_on_tick_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(time_load && second_tick)
    ) else $error("time_keeper_12h: load collided with second tick");

endmodule

/* alarm_match.sv */
`timescale 1ns/1ps

module alarm_match (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         alarm_load,
    input  logic [clock_pkg::TIME_W-1:0] alarm_time,
    input  logic                         alarm_pm,
    input  logic [clock_pkg::TIME_W-1:0] time_now,
    input  logic                         pm,
    input  logic                         time_step,  // Compare strobe
    input  logic                         alarm_ack,
    output logic                         alarm       // Sticky until ack
);
    import clock_pkg::*;

    logic [TIME_W-1:0] alarm_time_q;
    logic              alarm_pm_q;
    logic              hit;

    ////////////////////////////////////////
    // Alarm setting
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            alarm_time_q <= ALARM_RESET_TIME;  // Unreachable time
            alarm_pm_q   <= 1'b0;
        end
        else if (alarm_load)
        begin
            alarm_time_q <= alarm_time;
            alarm_pm_q   <= alarm_pm;
        end
    end

    // All six digits plus AM/PM on a fresh time
    assign hit = time_step && (time_now == alarm_time_q) && (pm == alarm_pm_q);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            alarm <= 1'b0;
        else if (alarm_ack)
            alarm <= 1'b0;   // Ack beats a same-cycle hit
        else if (hit)
            alarm <= 1'b1;
    end

endmodule

/* seg7_scan.sv */
`timescale 1ns/1ps

module seg7_scan (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [clock_pkg::TIME_W-1:0]     time_now,
    output logic [clock_pkg::SEG_W-1:0]      seg,        // a..g, bit 0 is a
    output logic [clock_pkg::NUM_DIGITS-1:0] digit_sel   // One-hot, bit 0 is seconds units
);
    import clock_pkg::*;

    logic [$clog2(SCAN_HOLD)-1:0]  hold_cnt;
    logic [$clog2(NUM_DIGITS)-1:0] digit_idx;
    logic [$clog2(NUM_DIGITS)-1:0] idx_next;   // Digit shown after this edge
    logic                          advance;
    logic [BCD_W-1:0]              digit_val;

    // BCD to segments, bit order g..a
    function automatic logic [SEG_W-1:0] seg_decode(input logic [BCD_W-1:0] digit);
        case (digit)
            4'd0:    seg_decode = 7'b011_1111;
            4'd1:    seg_decode = 7'b000_0110;
            4'd2:    seg_decode = 7'b101_1011;
            4'd3:    seg_decode = 7'b100_1111;
            4'd4:    seg_decode = 7'b110_0110;
            4'd5:    seg_decode = 7'b110_1101;
            4'd6:    seg_decode = 7'b111_1101;
            4'd7:    seg_decode = 7'b000_0111;
            4'd8:    seg_decode = 7'b111_1111;
            4'd9:    seg_decode = 7'b110_1111;
            default: seg_decode = '0;   // Blank on non-BCD
        endcase
    endfunction

    ////////////////////////////////////////
    // Scan position
    ////////////////////////////////////////
    assign advance = (hold_cnt == $bits(hold_cnt)'(SCAN_HOLD - 1));

    always_comb
    begin
        idx_next = digit_idx;
        if (advance)
        begin
            if (digit_idx == $bits(digit_idx)'(NUM_DIGITS - 1))
                idx_next = '0;                 // Back to seconds units
            else
                idx_next = digit_idx + 1'b1;
        end
    end

    assign digit_val = time_now[idx_next * BCD_W +: BCD_W];

    // Select and pattern move on the same edge
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hold_cnt  <= '0;
            digit_idx <= '0;
            digit_sel <= NUM_DIGITS'(1);
            seg       <= seg_decode(RESET_TIME[BCD_W-1:0]);
        end
        else
        begin
            hold_cnt  <= advance ? '0 : hold_cnt + 1'b1;
            digit_idx <= idx_next;
            digit_sel <= NUM_DIGITS'(1) << idx_next;
            seg       <= seg_decode(digit_val);  // Refreshed every cycle
        end
    end

    digit_sel_onehot_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot(digit_sel)
    ) else $error("seg7_scan: digit_sel %b not one-hot", digit_sel);

endmodule

/* digital_clock_top.sv */
`timescale 1ns/1ps

module digital_clock_top (
    input  logic                             clk,
    input  logic                             arst_n,
    // Set port
    input  logic                             set_valid,
    input  logic                             set_alarm,  // 1 targets the alarm
    input  logic                             set_pm,
    input  logic [clock_pkg::TIME_W-1:0]     set_time,
    output logic                             set_ready,
    // Alarm
    input  logic                             alarm_ack,
    output logic                             alarm,
    // Time and display
    output logic [clock_pkg::TIME_W-1:0]     time_now,
    output logic                             pm,
    output logic [clock_pkg::SEG_W-1:0]      seg,
    output logic [clock_pkg::NUM_DIGITS-1:0] digit_sel
);

    logic second_tick;
    logic set_accept;
    logic time_load, alarm_load;
    logic time_step;

    ////////////////////////////////////////
    // Set port arbitration
    ////////////////////////////////////////
    assign set_ready  = !second_tick;            // Tick owns the keeper this cycle
    assign set_accept = set_valid && set_ready;
    assign time_load  = set_accept && !set_alarm;
    assign alarm_load = set_accept && set_alarm;

    tick_prescaler tick_prescaler_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .second_tick (second_tick)
    );

    time_keeper_12h time_keeper_12h_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .second_tick (second_tick),
        .time_load   (time_load),
        .load_time   (set_time),
        .load_pm     (set_pm),
        .time_now    (time_now),
        .pm          (pm),
        .time_step   (time_step)
    );

    alarm_match alarm_match_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .alarm_load (alarm_load),
        .alarm_time (set_time),
        .alarm_pm   (set_pm),
        .time_now   (time_now),
        .pm         (pm),
        .time_step  (time_step),
        .alarm_ack  (alarm_ack),
        .alarm      (alarm)
    );

    seg7_scan seg7_scan_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .time_now  (time_now),
        .seg       (seg),
        .digit_sel (digit_sel)
    );

    // Sender keeps a stalled command intact
    set_hold_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        set_valid && !set_ready |=> set_valid && $stable({set_alarm, set_pm, set_time})
    ) else $error("digital_clock_top: set command changed before transfer");

endmodule

/* tb_digital_clock.sv */
`timescale 1ns/1ps

module tb_digital_clock;
    import clock_pkg::*;

    localparam int CLK_HALF     = 50;     // 100 ns period
    localparam int DRIVE_DELAY  = 10;     // Inputs change this long after the edge
    localparam int RESET_CYCLES = 5;
    localparam int MAX_CYCLES   = 20000;  // Far above the few hundred cycles needed

    logic                  clk, arst_n;
    logic                  set_valid, set_alarm, set_pm, set_ready;
    logic [TIME_W-1:0]     set_time, time_now;
    logic                  alarm_ack, alarm, pm;
    logic [SEG_W-1:0]      seg;
    logic [NUM_DIGITS-1:0] digit_sel;

    int                    cycle_count = 0;
    int                    errors = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;
    int                    ticks_seen = 0;   // Seconds applied to the model
    int                    stall_count = 0;  // Cycles a command waited on set_ready
    logic [TIME_W-1:0]     model_time = 24'h12_00_00;
    logic                  model_pm = 1'b0;
    logic [31:0]           lcg_state = 32'd56;
    logic [SEG_W-1:0]      seg_table [10];   // Bit 0 is segment a

    digital_clock_top digital_clock_top_inst (
        .clk(clk), .arst_n(arst_n),
        .set_valid(set_valid), .set_alarm(set_alarm), .set_pm(set_pm),
        .set_time(set_time), .set_ready(set_ready),
        .alarm_ack(alarm_ack), .alarm(alarm),
        .time_now(time_now), .pm(pm), .seg(seg), .digit_sel(digit_sel)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Watchdog
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: still running after %0d clock cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'({17'd0, lcg_state[30:16]});  // Upper bits spread better
    endfunction

    function automatic logic [7:0] to_bcd(input int n);
        return {4'(n / 10), 4'(n % 10)};
    endfunction

    function automatic int from_bcd(input logic [7:0] b);
        return b[7:4] * 10 + b[3:0];
    endfunction

    function automatic logic [TIME_W-1:0] random_time();
        int h;
        int m;
        int s;
        h = lcg_next() % 12 + 1;  // 01..12
        m = lcg_next() % 60;
        s = lcg_next() % 60;
        return {to_bcd(h), to_bcd(m), to_bcd(s)};
    endfunction

    // High in the cycle where second_tick is due
    // First one comes TICK_DIV cycles out of reset
    function automatic logic tick_window();
        int n;
        n = cycle_count - RESET_CYCLES;
        return (n >= TICK_DIV) && (n % TICK_DIV == 0);
    endfunction

    task automatic fill_seg_table();
        seg_table[0] = 7'h3F;  // a b c d e f
        seg_table[1] = 7'h06;
        seg_table[2] = 7'h5B;
        seg_table[3] = 7'h4F;
        seg_table[4] = 7'h66;
        seg_table[5] = 7'h6D;
        seg_table[6] = 7'h7D;
        seg_table[7] = 7'h07;
        seg_table[8] = 7'h7F;
        seg_table[9] = 7'h6F;  // a b c d f g
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - start_errors);
        end
    endtask

    // Reference model steps one second in 12-hour time
    task automatic advance_model();
        int h;
        int m;
        int s;
        h = from_bcd(model_time[HOUR_LO_POS +: 8]);
        m = from_bcd(model_time[MIN_LO_POS +: 8]);
        s = from_bcd(model_time[SEC_LO_POS +: 8]) + 1;
        if (s == 60)
        begin
            s = 0;
            m = m + 1;
        end
        if (m == 60)
        begin
            m = 0;
            if (h == 11)
                model_pm = !model_pm;  // 11 -> 12 flips AM/PM
            h = (h == 12) ? 1 : h + 1;  // No hour 00
        end
        model_time = {to_bcd(h), to_bcd(m), to_bcd(s)};
    endtask

    // One clock with model tracking and set_ready check
    task automatic clock_cycle();
        logic              tick_due;
        logic              load_due;
        logic [TIME_W-1:0] cmd_time;
        logic              cmd_pm;
        tick_due = tick_window();
        load_due = set_valid && !set_alarm && !tick_due;  // Tick holds off a load
        cmd_time = set_time;
        cmd_pm   = set_pm;
        if (set_valid && !set_ready)
            stall_count++;
        if (set_ready !== !tick_due)
            mismatch("set_ready", set_ready, !tick_due);
        @(posedge clk);
        #DRIVE_DELAY;
        if (tick_due)
        begin
            advance_model();
            ticks_seen++;
        end
        else if (load_due)
        begin
            model_time = cmd_time;
            model_pm   = cmd_pm;
        end
        if (time_now !== model_time)
            mismatch("time_now", time_now, model_time);
        if (pm !== model_pm)
            mismatch("pm", pm, model_pm);
    endtask

    // Holds the command until it transfers
    task automatic send_set(input logic to_alarm, input logic p, input logic [TIME_W-1:0] t);
        logic taken;
        set_valid = 1'b1;
        set_alarm = to_alarm;
        set_pm    = p;
        set_time  = t;
        taken     = 1'b0;
        while (!taken)
        begin
            taken = !tick_window();
            clock_cycle();
        end
        set_valid = 1'b0;
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic reset_test();
        int start_errors;
        start_errors = errors;
        if (time_now !== 24'h12_00_00)
            mismatch("time_now", time_now, 24'h12_00_00);
        if (pm !== 1'b0)
            mismatch("pm", pm, 1'b0);
        if (alarm !== 1'b0)
            mismatch("alarm", alarm, 1'b0);
        if (set_ready !== 1'b1)
            mismatch("set_ready", set_ready, 1'b1);
        if (digit_sel !== 6'b00_0001)
            mismatch("digit_sel", digit_sel, 6'b00_0001);
        finish_test("reset_values", start_errors);
    endtask

    task automatic count_test();
        int start_errors;
        int start_ticks;
        start_errors = errors;
        send_set(1'b0, 1'b0, 24'h11_59_55);
        start_ticks = ticks_seen;
        while (ticks_seen < start_ticks + 10)
            clock_cycle();
        if (time_now !== 24'h12_00_05)
            mismatch("time_now", time_now, 24'h12_00_05);
        if (pm !== 1'b1)                     // Noon crossed
            mismatch("pm", pm, 1'b1);
        send_set(1'b0, 1'b1, 24'h12_59_58);
        start_ticks = ticks_seen;
        while (ticks_seen < start_ticks + 3)
            clock_cycle();
        if (time_now !== 24'h01_00_01)
            mismatch("time_now", time_now, 24'h01_00_01);
        if (pm !== 1'b1)                     // 12 -> 01 keeps PM
            mismatch("pm", pm, 1'b1);
        finish_test("counting", start_errors);
    endtask

    task automatic set_port_test();
        int                start_errors;
        int                start_stalls;
        logic [TIME_W-1:0] cmd_time;
        logic              cmd_pm;
        start_errors = errors;
        start_stalls = stall_count;
        for (int i = 0; i < 8; i++)
        begin
            cmd_time = random_time();
            cmd_pm   = (lcg_next() % 2) == 1;
            if (i == 0)
            begin
                while (!tick_window())  // Meet a tick head on
                    clock_cycle();
            end
            else
            begin
                repeat (lcg_next() % TICK_DIV) clock_cycle();
            end
            send_set(1'b0, cmd_pm, cmd_time);
            if (time_now !== cmd_time)
                mismatch("time_now", time_now, cmd_time);
            if (pm !== cmd_pm)
                mismatch("pm", pm, cmd_pm);
        end
        if (stall_count == start_stalls)
            note_failure("no command was ever held off by set_ready");
        finish_test("set_handshake", start_errors);
    endtask

    task automatic alarm_test();
        int start_errors;
        int start_ticks;
        start_errors = errors;
        send_set(1'b1, 1'b1, 24'h01_00_03);  // Alarm 01:00:03 PM
        send_set(1'b0, 1'b1, 24'h01_00_00);
        while (model_time !== 24'h01_00_03)
        begin
            if (alarm !== 1'b0)
                mismatch("alarm", alarm, 1'b0);
            clock_cycle();
        end
        if (alarm !== 1'b0)                  // Rises one cycle after the match
            mismatch("alarm", alarm, 1'b0);
        clock_cycle();
        if (alarm !== 1'b1)
            mismatch("alarm", alarm, 1'b1);
        start_ticks = ticks_seen;
        while (ticks_seen < start_ticks + 2)
        begin
            clock_cycle();
            if (alarm !== 1'b1)              // Sticky
                mismatch("alarm", alarm, 1'b1);
        end
        alarm_ack = 1'b1;
        clock_cycle();
        alarm_ack = 1'b0;
        if (alarm !== 1'b0)
            mismatch("alarm", alarm, 1'b0);
        // Right digits but wrong half of the day
        send_set(1'b1, 1'b0, 24'h01_00_08);
        while (model_time !== 24'h01_00_10)
        begin
            clock_cycle();
            if (alarm !== 1'b0)
                mismatch("alarm", alarm, 1'b0);
        end
        clock_cycle();
        if (alarm !== 1'b0)
            mismatch("alarm", alarm, 1'b0);
        finish_test("alarm", start_errors);
    endtask

    task automatic scan_test();
        int                    start_errors;
        int                    sel_idx;
        logic [NUM_DIGITS-1:0] seen;
        logic [TIME_W-1:0]     prev_time;
        logic [SEG_W-1:0]      expected_seg;
        start_errors = errors;
        seen = '0;
        send_set(1'b0, 1'b0, 24'h10_48_57);  // Six distinct digits
        repeat (NUM_DIGITS * SCAN_HOLD)
        begin
            prev_time = time_now;            // Pattern is registered from this word
            clock_cycle();
            if (!$onehot(digit_sel))
            begin
                note_failure($sformatf("digit_sel %b is not one-hot", digit_sel));
            end
            else
            begin
                sel_idx = 0;
                for (int k = 0; k < NUM_DIGITS; k++)
                    if (digit_sel[k])
                        sel_idx = k;
                seen = seen | digit_sel;
                expected_seg = seg_table[prev_time[sel_idx * BCD_W +: BCD_W]];
                if (seg !== expected_seg)
                    mismatch("seg", seg, expected_seg);
            end
        end
        if (seen !== '1)
            note_failure("not every digit position was selected during the scan");
        finish_test("display_scan", start_errors);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial
    begin
        arst_n    = 1'b0;
        set_valid = 1'b0;
        set_alarm = 1'b0;
        set_pm    = 1'b0;
        set_time  = '0;
        alarm_ack = 1'b0;
        fill_seg_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        reset_test();
        count_test();
        set_port_test();
        alarm_test();
        scan_test();
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* digital_clock_top.f */
clock_pkg.sv
bcd_digit_counter.sv
tick_prescaler.sv
time_keeper_12h.sv
alarm_match.sv
seg7_scan.sv
digital_clock_top.sv
tb_digital_clock.sv

/* run.sh */
#!/bin/sh
# Build and run the clock testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_digital_clock -f digital_clock_top.f

out=$(./obj_dir/Vtb_digital_clock)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Regression passed"
